// File: include/pcs_tx_config.svh
`ifndef PCS_TX_CONFIG_SVH
`define PCS_TX_CONFIG_SVH

// Widths fixed by 10GBASE-R
`define PCS_TX_DATA_W    64
`define PCS_TX_CTRL_W    8
`define PCS_TX_BLOCK_W   66

// Sync headers
`define PCS_TX_SYNC_DATA 2'b01
`define PCS_TX_SYNC_CTRL 2'b10

// Block type field values
`define PCS_TX_BT_IDLE   8'h1E
`define PCS_TX_BT_START  8'h78
`define PCS_TX_BT_TERM0  8'h87
`define PCS_TX_BT_TERM1  8'h99
`define PCS_TX_BT_TERM2  8'hAA
`define PCS_TX_BT_TERM3  8'hB4
`define PCS_TX_BT_TERM4  8'hCC
`define PCS_TX_BT_TERM5  8'hD2
`define PCS_TX_BT_TERM6  8'hE1
`define PCS_TX_BT_TERM7  8'hFF
`define PCS_TX_BT_FAULT  8'h4B

// XGMII control characters
`define PCS_TX_XG_IDLE   8'h07
`define PCS_TX_XG_START  8'hFB
`define PCS_TX_XG_TERM   8'hFD
`define PCS_TX_XG_ERROR  8'hFE

// 7-bit PCS control characters
`define PCS_TX_PCS_IDLE  7'h00
`define PCS_TX_PCS_ERROR 7'h1E

`define PCS_TX_SCR_SEED  58'h3FF_FFFF_FFFF_FFFF

`endif

// File: hdl/pcs_tx_pkg.sv
`include "pcs_tx_config.svh"

package pcs_tx_pkg;

  // Block classes seen by the sequence check
  typedef enum logic [2:0]
  {
    BLK_D = 3'd0,  // All data
    BLK_S = 3'd1,  // Start
    BLK_C = 3'd2,  // Idle
    BLK_T = 3'd3,  // Terminate
    BLK_E = 3'd4   // Invalid
  } blk_type_e;

  // Field after the block type
  typedef union packed
  {
    logic [7:0][6:0] chars;  // Idle and error blocks
    logic [55:0]     raw;    // Data bytes mixed with characters
  } ctrl_field_u;

  typedef struct packed
  {
    ctrl_field_u field;
    logic [7:0]  btype;      // First on the wire, so lowest bits
  } ctrl_view_s;

  // Payload of a 66-bit block, read as data or as control
  typedef union packed
  {
    logic [`PCS_TX_DATA_W/8-1:0][7:0] data;
    ctrl_view_s                       ctrl;
  } payload_u;

endpackage

// File: hdl/pcs_tx_block_if.sv
`timescale 1ns/10ps

interface pcs_tx_block_if;

  logic                  valid;    // One cycle per block
  logic [1:0]            sync;
  pcs_tx_pkg::payload_u  payload;
  pcs_tx_pkg::blk_type_e kind;

  modport source
  (
    output valid,
    output sync,
    output payload,
    output kind
  );

  modport sink
  (
    input valid,
    input sync,
    input payload,
    input kind
  );

endinterface

// File: hdl/pcs_tx_encoder.sv
`timescale 1ns/10ps
`include "pcs_tx_config.svh"

module pcs_tx_encoder
(
  input  logic                      i_clock,
  input  logic                      i_reset,
  input  logic                      i_valid,
  input  logic [`PCS_TX_DATA_W-1:0] i_txd,
  input  logic [`PCS_TX_CTRL_W-1:0] i_txc,
  pcs_tx_block_if.source            o_blk
);

  // Terminate type indexed by the lane holding /T/
  localparam logic [7:0][7:0] TERM_TYPE =
  {
    `PCS_TX_BT_TERM7, `PCS_TX_BT_TERM6, `PCS_TX_BT_TERM5, `PCS_TX_BT_TERM4,
    `PCS_TX_BT_TERM3, `PCS_TX_BT_TERM2, `PCS_TX_BT_TERM1, `PCS_TX_BT_TERM0
  };

  logic [7:0][7:0]       lane;
  logic [7:0]            lane_idle;
  logic [7:0]            term_hit;
  logic [1:0]            blk_sync;
  pcs_tx_pkg::payload_u  blk_payload;
  pcs_tx_pkg::blk_type_e blk_kind;

  assign lane = i_txd;  // Lane 0 in the low byte

  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      lane_idle[i] = (lane[i] == `PCS_TX_XG_IDLE);
    end
  end

  // Terminate in lane k: data below, idles above
  always_comb
  begin
    for (int k = 0; k < 8; k++)
    begin
      term_hit[k] = (i_txc == (8'hFF << k)) && (lane[k] == `PCS_TX_XG_TERM);
      for (int i = k + 1; i < 8; i++)
      begin
        term_hit[k] = term_hit[k] && lane_idle[i];
      end
    end
  end

  always_comb
  begin
    // Default is the error block
    blk_sync                      = `PCS_TX_SYNC_CTRL;
    blk_kind                      = pcs_tx_pkg::BLK_E;
    blk_payload.ctrl.btype        = `PCS_TX_BT_IDLE;
    blk_payload.ctrl.field.chars  = {8{`PCS_TX_PCS_ERROR}};

    if (i_txc == '0)
    begin
      blk_sync         = `PCS_TX_SYNC_DATA;
      blk_kind         = pcs_tx_pkg::BLK_D;
      blk_payload.data = lane;
    end
    else if ((i_txc == '1) && (&lane_idle))
    begin
      blk_kind                     = pcs_tx_pkg::BLK_C;
      blk_payload.ctrl.field.chars = {8{`PCS_TX_PCS_IDLE}};
    end
    else if ((i_txc == 8'h01) && (lane[0] == `PCS_TX_XG_START))
    begin
      blk_kind                   = pcs_tx_pkg::BLK_S;
      blk_payload.ctrl.btype     = `PCS_TX_BT_START;
      blk_payload.ctrl.field.raw = i_txd[`PCS_TX_DATA_W-1:8];  // D1..D7
    end
    else
    begin
      for (int k = 0; k < 8; k++)
      begin
        if (term_hit[k])
        begin
          blk_kind                   = pcs_tx_pkg::BLK_T;
          blk_payload.ctrl.btype     = TERM_TYPE[k];
          blk_payload.ctrl.field.raw = '0;  // Pad bits
          for (int i = 0; i < 7; i++)
          begin
            if (i < k)
            begin
              blk_payload.ctrl.field.raw[8*i +: 8] = lane[i];
            end
          end
          // Trailing characters packed from the top of the field
          for (int j = 0; j < 7; j++)
          begin
            if (j < 7 - k)
            begin
              blk_payload.ctrl.field.raw[55-7*j -: 7] = `PCS_TX_PCS_IDLE;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      o_blk.valid <= 1'b0;
    end
    else
    begin
      o_blk.valid <= i_valid;
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_valid)
    begin
      o_blk.sync    <= blk_sync;
      o_blk.payload <= blk_payload;
      o_blk.kind    <= blk_kind;
    end
  end

  a_valid_known: assert property (@(posedge i_clock) disable iff (i_reset)
    !$isunknown(o_blk.valid))
    else $error("Encoder valid unknown after reset");

endmodule

// File: hdl/pcs_tx_sequence_check.sv
`timescale 1ns/10ps
`include "pcs_tx_config.svh"

module pcs_tx_sequence_check
(
  input  logic           i_clock,
  input  logic           i_reset,
  pcs_tx_block_if.sink   i_blk,
  pcs_tx_block_if.source o_blk
);

  typedef enum logic [4:0]
  {
    ST_INIT = 5'b10000,
    ST_C    = 5'b01000,
    ST_D    = 5'b00100,
    ST_T    = 5'b00010,
    ST_E    = 5'b00001
  } state_e;

  // Local fault block with D3 = 01, O0 = 0 and idle C4..C7
  localparam pcs_tx_pkg::payload_u LF_PAYLOAD =
    {{4{`PCS_TX_PCS_IDLE}}, 4'h0, 8'h01, 8'h00, 8'h00, `PCS_TX_BT_FAULT};
  localparam pcs_tx_pkg::payload_u ERR_PAYLOAD =
    {{8{`PCS_TX_PCS_ERROR}}, `PCS_TX_BT_IDLE};

  state_e state;
  state_e state_next;
  logic   legal;

  always_comb
  begin
    state_next = state;
    legal      = 1'b0;
    case (state)
      ST_INIT, ST_C, ST_T:
      begin
        if (i_blk.kind == pcs_tx_pkg::BLK_C)
        begin
          state_next = ST_C;
          legal      = 1'b1;
        end
        else if (i_blk.kind == pcs_tx_pkg::BLK_S)
        begin
          state_next = ST_D;
          legal      = 1'b1;
        end
      end
      ST_D:
      begin
        if (i_blk.kind == pcs_tx_pkg::BLK_D)
        begin
          legal = 1'b1;
        end
        else if (i_blk.kind == pcs_tx_pkg::BLK_T)
        begin
          state_next = ST_T;
          legal      = 1'b1;
        end
      end
      ST_E:
      begin
        legal = 1'b1;  // Cleared below for S and E
        case (i_blk.kind)
          pcs_tx_pkg::BLK_T: state_next = ST_T;
          pcs_tx_pkg::BLK_D: state_next = ST_D;
          pcs_tx_pkg::BLK_C: state_next = ST_C;
          default:           legal      = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    if (!legal)
    begin
      state_next = ST_E;
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      state         <= ST_INIT;
      o_blk.valid   <= 1'b0;
      o_blk.sync    <= `PCS_TX_SYNC_CTRL;
      o_blk.payload <= LF_PAYLOAD;
      o_blk.kind    <= pcs_tx_pkg::BLK_E;
    end
    else
    begin
      o_blk.valid <= i_blk.valid;
      if (i_blk.valid)
      begin
        state <= state_next;
        if (legal)
        begin
          o_blk.sync    <= i_blk.sync;
          o_blk.payload <= i_blk.payload;
          o_blk.kind    <= i_blk.kind;
        end
        else
        begin
          o_blk.sync    <= `PCS_TX_SYNC_CTRL;
          o_blk.payload <= ERR_PAYLOAD;
          o_blk.kind    <= pcs_tx_pkg::BLK_E;
        end
      end
    end
  end

  a_state_legal: assert property (@(posedge i_clock) disable iff (i_reset)
    $onehot(state))
    else $error("Sequence check state not one-hot");

  // Only data blocks leave with the data header
  a_sync_kind: assert property (@(posedge i_clock) disable iff (i_reset)
    o_blk.valid |-> (o_blk.sync == ((o_blk.kind == pcs_tx_pkg::BLK_D) ?
      `PCS_TX_SYNC_DATA : `PCS_TX_SYNC_CTRL)))
    else $error("Sync header does not match block kind");

endmodule

// File: hdl/pcs_tx_scrambler.sv
`timescale 1ns/10ps
`include "pcs_tx_config.svh"

module pcs_tx_scrambler
(
  input  logic                       i_clock,
  input  logic                       i_reset,
  pcs_tx_block_if.sink               i_blk,
  output logic                       o_valid,
  output logic [`PCS_TX_BLOCK_W-1:0] o_block
);

  localparam int SCR_W = $bits(`PCS_TX_SCR_SEED);

  logic [SCR_W-1:0]          scr_state;  // Bit 0 is the newest scrambled bit
  logic [SCR_W-1:0]          scr_next;
  logic [`PCS_TX_DATA_W-1:0] scr_data;

  // x^58 + x^39 + 1, LSB first
  always_comb
  begin
    scr_next = scr_state;
    for (int i = 0; i < `PCS_TX_DATA_W; i++)
    begin
      scr_data[i] = i_blk.payload[i] ^ scr_next[38] ^ scr_next[SCR_W-1];
      scr_next    = {scr_next[SCR_W-2:0], scr_data[i]};
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_reset)
    begin
      o_valid   <= 1'b0;
      scr_state <= `PCS_TX_SCR_SEED;
    end
    else
    begin
      o_valid <= i_blk.valid;
      if (i_blk.valid)
      begin
        scr_state <= scr_next;
      end
    end
  end

  always_ff @(posedge i_clock)
  begin
    if (i_blk.valid)
    begin
      o_block <= {i_blk.sync, scr_data};  // Header goes out in the clear
    end
  end

  a_sync_legal: assert property (@(posedge i_clock) disable iff (i_reset)
    o_valid |-> (o_block[`PCS_TX_BLOCK_W-1 -: 2] inside {`PCS_TX_SYNC_DATA, `PCS_TX_SYNC_CTRL}))
    else $error("Illegal sync header at output");

endmodule

// File: hdl/pcs_tx_top.sv
`timescale 1ns/10ps
`include "pcs_tx_config.svh"

module pcs_tx_top
(
  input  logic                       i_clock,
  input  logic                       i_reset,
  input  logic                       i_valid,
  input  logic [`PCS_TX_DATA_W-1:0]  i_txd,
  input  logic [`PCS_TX_CTRL_W-1:0]  i_txc,
  output logic                       o_valid,
  output logic [`PCS_TX_BLOCK_W-1:0] o_block
);

  pcs_tx_block_if enc_blk ();
  pcs_tx_block_if chk_blk ();

  pcs_tx_encoder u_encoder
  (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_txd   (i_txd),
    .i_txc   (i_txc),
    .o_blk   (enc_blk)
  );

  pcs_tx_sequence_check u_sequence_check
  (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_blk   (enc_blk),
    .o_blk   (chk_blk)
  );

  // Kind is dropped here
  pcs_tx_scrambler u_scrambler
  (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_blk   (chk_blk),
    .o_valid (o_valid),
    .o_block (o_block)
  );

endmodule

// File: sim/pcs_tx_tb.sv
`timescale 1ns/10ps
`include "pcs_tx_config.svh"

module pcs_tx_tb;

  localparam int DRAIN_LIMIT = 64;
  localparam logic [7:0] TERM_TYPES [8] = '{`PCS_TX_BT_TERM0, `PCS_TX_BT_TERM1,
    `PCS_TX_BT_TERM2, `PCS_TX_BT_TERM3, `PCS_TX_BT_TERM4, `PCS_TX_BT_TERM5,
    `PCS_TX_BT_TERM6, `PCS_TX_BT_TERM7};
  localparam logic [65:0] ERR_BLOCK =
    {`PCS_TX_SYNC_CTRL, {8{`PCS_TX_PCS_ERROR}}, `PCS_TX_BT_IDLE};
  localparam logic [63:0] IDLE_TXD = {8{`PCS_TX_XG_IDLE}};

  typedef enum {M_INIT, M_C, M_D, M_T, M_E} model_state_e;

  logic        i_clock;
  logic        i_reset;
  logic        i_valid;
  logic [63:0] i_txd;
  logic [7:0]  i_txc;
  logic        o_valid;
  logic [65:0] o_block;

  logic [65:0]  exp_q [$];
  model_state_e model_state = M_INIT;
  int           tx_count = 0;
  int           rx_count = 0;
  logic [2:0]   vld_d = '0;   // i_valid three stages back
  logic         rst_seen = 1'b0;
  logic [57:0]  desc_state;
  logic [65:0]  got_block;
  logic [65:0]  exp_head;
  logic         chk_en = 1'b0;
  logic         have_exp;

  pcs_tx_top uut
  (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .i_valid (i_valid),
    .i_txd   (i_txd),
    .i_txc   (i_txc),
    .o_valid (o_valid),
    .o_block (o_block)
  );

  always #2 i_clock = ~i_clock;

  always @(posedge i_clock)
  begin
    if (i_reset)
    begin
      rst_seen <= 1'b1;
      vld_d    <= '0;
    end
    else
    begin
      vld_d <= {vld_d[1:0], i_valid};
    end
  end

  // Descrambler model on the falling edge
  always @(negedge i_clock)
  begin
    logic [63:0] plain;
    chk_en = 1'b0;
    if (i_reset)
    begin
      desc_state = `PCS_TX_SCR_SEED;
    end
    else if (o_valid === 1'b1)
    begin
      for (int i = 0; i < 64; i++)
      begin
        plain[i]   = o_block[i] ^ desc_state[38] ^ desc_state[57];
        desc_state = {desc_state[56:0], o_block[i]};  // Fed by received bits
      end
      got_block = {o_block[65:64], plain};
      have_exp  = (exp_q.size() > 0);
      exp_head  = have_exp ? exp_q.pop_front() : '0;
      chk_en    = 1'b1;
      rx_count++;
    end
  end

  a_valid_delay: assert property (@(posedge i_clock) !rst_seen || (o_valid === vld_d[2]))
    else stop_with_error($sformatf("ERROR %0t: o_valid %b, expected %b", $time, o_valid,
      vld_d[2]));

  a_block_match: assert property (@(posedge i_clock)
    !chk_en || (have_exp && (got_block == exp_head)))
    else stop_with_error($sformatf("ERROR %0t: block %h, expected %h", $time, got_block,
      exp_head));

  a_scrambled: assert property (@(posedge i_clock) !chk_en || (o_block[63:0] != exp_head[63:0]))
    else stop_with_error($sformatf("ERROR %0t: payload %h left unscrambled", $time,
      o_block[63:0]));

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  function automatic logic [65:0] encode_word(input logic [63:0] txd, input logic [7:0] txc,
                                              output pcs_tx_pkg::blk_type_e kind);
    logic [65:0] blk;
    logic [55:0] field;
    logic        hit;
    kind = pcs_tx_pkg::BLK_E;
    blk  = ERR_BLOCK;
    if (txc == 8'h00)
    begin
      kind = pcs_tx_pkg::BLK_D;
      blk  = {`PCS_TX_SYNC_DATA, txd};
    end
    else if ((txc == 8'hFF) && (txd == IDLE_TXD))
    begin
      kind = pcs_tx_pkg::BLK_C;
      blk  = {`PCS_TX_SYNC_CTRL, {8{`PCS_TX_PCS_IDLE}}, `PCS_TX_BT_IDLE};
    end
    else if ((txc == 8'h01) && (txd[7:0] == `PCS_TX_XG_START))
    begin
      kind = pcs_tx_pkg::BLK_S;
      blk  = {`PCS_TX_SYNC_CTRL, txd[63:8], `PCS_TX_BT_START};
    end
    else
    begin
      for (int k = 0; k < 8; k++)
      begin
        hit   = (txc == 8'(8'hFF << k)) && (txd[8*k +: 8] == `PCS_TX_XG_TERM);
        field = '0;  // Idle characters and pad are zero
        for (int i = 0; i < 8; i++)
        begin
          if (i > k)
          begin
            hit = hit && (txd[8*i +: 8] == `PCS_TX_XG_IDLE);
          end
          else if (i < k)
          begin
            field[8*i +: 8] = txd[8*i +: 8];
          end
        end
        if (hit)
        begin
          kind = pcs_tx_pkg::BLK_T;
          blk  = {`PCS_TX_SYNC_CTRL, field, TERM_TYPES[k]};
        end
      end
    end
    return blk;
  endfunction

  // Block order rules that also advance the model state
  function automatic logic order_legal(input pcs_tx_pkg::blk_type_e kind);
    logic legal;
    legal = 1'b1;
    case (model_state)
      M_INIT, M_C, M_T:
        if (kind == pcs_tx_pkg::BLK_C) model_state = M_C;
        else if (kind == pcs_tx_pkg::BLK_S) model_state = M_D;
        else legal = 1'b0;
      M_D:
        if (kind == pcs_tx_pkg::BLK_T) model_state = M_T;
        else if (kind != pcs_tx_pkg::BLK_D) legal = 1'b0;
      default:
        if (kind == pcs_tx_pkg::BLK_T) model_state = M_T;
        else if (kind == pcs_tx_pkg::BLK_D) model_state = M_D;
        else if (kind == pcs_tx_pkg::BLK_C) model_state = M_C;
        else legal = 1'b0;
    endcase
    if (!legal)
    begin
      model_state = M_E;
    end
    return legal;
  endfunction

  task automatic send_word(input logic [63:0] txd, input logic [7:0] txc);
    int                    gap;
    pcs_tx_pkg::blk_type_e kind;
    logic [65:0]           blk;
    gap = ($urandom % 4 == 0) ? 1 + int'($urandom % 3) : 0;
    repeat (gap)
    begin
      @(posedge i_clock);
      #1 i_valid = 1'b0;
    end
    @(posedge i_clock);
    #1;
    i_valid = 1'b1;
    i_txd   = txd;
    i_txc   = txc;
    blk     = encode_word(txd, txc, kind);
    exp_q.push_back(order_legal(kind) ? blk : ERR_BLOCK);
    tx_count++;
  endtask

  task automatic send_idle();
    send_word(IDLE_TXD, 8'hFF);
  endtask

  task automatic send_start();
    logic [63:0] txd;
    txd      = {$urandom, $urandom};
    txd[7:0] = `PCS_TX_XG_START;
    send_word(txd, 8'h01);
  endtask

  task automatic send_data();
    send_word({$urandom, $urandom}, 8'h00);
  endtask

  task automatic send_term(input int k);
    logic [63:0] txd;
    txd = {$urandom, $urandom};
    txd[8*k +: 8] = `PCS_TX_XG_TERM;
    for (int i = k + 1; i < 8; i++)
    begin
      txd[8*i +: 8] = `PCS_TX_XG_IDLE;
    end
    send_word(txd, 8'(8'hFF << k));
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    @(posedge i_clock);
    #1 i_valid = 1'b0;
    while (rx_count != tx_count)
    begin
      @(posedge i_clock);
      cycles++;
      if (cycles > DRAIN_LIMIT)
      begin
        stop_with_error("Timed out waiting for the DUT to deliver every block");
      end
    end
    repeat (2) @(posedge i_clock);  // Let the last checks fire
  endtask

  initial
  begin
    void'($urandom(55276));
    i_clock = 1'b0;
    i_reset = 1'b1;
    i_valid = 1'b0;
    i_txd   = '0;
    i_txc   = '0;
    repeat (4) @(posedge i_clock);
    #1 i_reset = 1'b0;
    repeat (5) @(posedge i_clock);

    repeat (8) send_idle();
    for (int k = 0; k < 8; k++)
    begin
      send_start();
      repeat (1 + $urandom % 3) send_data();
      send_term(k);
      send_idle();
    end

    // Data after idle and recovery through D and T
    send_idle();
    send_data();
    send_data();
    send_term(3);
    send_idle();
    // Start inside a frame
    send_start();
    send_data();
    send_start();
    send_data();
    send_term(5);
    send_idle();
    // Idle straight after start
    send_start();
    send_idle();
    send_idle();

    // XGMII error character and an unsupported control pattern
    send_word({{7{`PCS_TX_XG_IDLE}}, `PCS_TX_XG_ERROR}, 8'hFF);
    send_idle();
    send_start();
    send_data();
    send_word({$urandom, $urandom}, 8'h10);
    send_data();
    send_term(0);
    send_idle();
    wait_drain();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: pcs_tx.f
+incdir+include
hdl/pcs_tx_pkg.sv
hdl/pcs_tx_block_if.sv
hdl/pcs_tx_encoder.sv
hdl/pcs_tx_sequence_check.sv
hdl/pcs_tx_scrambler.sv
hdl/pcs_tx_top.sv
sim/pcs_tx_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= pcs_tx_tb
FILELIST  ?= pcs_tx.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
